//--- Bender.yml
package:
  name: attn_score

sources:
  - common/attn_pkg.sv
  - tile_fetch/tile_fetch.sv
  - score_accum/score_accum.sv
  - verilog/score_writer.sv
  - verilog/attn_score_top.sv
  - target: test
    files:
      - testbench/tb_clock.sv
      - testbench/tb_attn_score.sv

//--- common/attn_pkg.sv
package attn_pkg;

    //////////////////////////////////////////////////////////////////////
    // sizes and number format
    //////////////////////////////////////////////////////////////////////
    localparam int TILE      = 4;   // tile edge
    localparam int D_W       = 16;  // signed q8.8
    localparam int ACC_W     = 40;  // full width sum
    localparam int FRAC      = 8;   // fraction bits
    localparam int COL_TILES = 4;   // d_k = 16
    localparam int Q_TILES   = 4;
    localparam int K_TILES   = 4;

    localparam logic signed [D_W-1:0] SCALE_DK = 16'sd64;  // 1/sqrt(16) in q8.8

    typedef logic [1:0] idx_t;  // tile index

    // tile[r][c], one 64 bit word per row
    typedef logic [TILE-1:0][TILE-1:0][D_W-1:0] tile_t;

    //////////////////////////////////////////////////////////////////////
    // transfer types
    //////////////////////////////////////////////////////////////////////
    typedef struct packed {
        idx_t q_line;
        idx_t k_line;
        idx_t col;
    } rd_req_t;

    typedef struct packed {
        tile_t q_tile;
        tile_t k_tile;
    } rd_data_t;

    typedef struct packed {
        tile_t q_tile;
        tile_t k_tile;
        logic  first;  // first column tile of a score tile
        logic  last;   // last column tile
    } opnd_t;

    typedef struct packed {
        logic [TILE-1:0][TILE-1:0][ACC_W-1:0] sum;
        idx_t                                 q_line;
        idx_t                                 k_line;
    } score_t;

    typedef struct packed {
        logic [TILE-1:0][D_W-1:0] data;
        idx_t                     q_line;
        idx_t                     k_line;
        idx_t                     row;  // row within the tile
    } wr_t;

endpackage

//--- compile.f
common/attn_pkg.sv
tile_fetch/tile_fetch.sv
score_accum/score_accum.sv
verilog/score_writer.sv
verilog/attn_score_top.sv
testbench/tb_clock.sv
testbench/tb_attn_score.sv

//--- score_accum/score_accum.sv
`timescale 1ns/100ps

module score_accum import attn_pkg::*; (
    input  logic   I_CLK,
    input  logic   I_RST_N,
    input  opnd_t  opnd_i,
    input  logic   opnd_vld_i,
    output score_t score_o,
    output logic   score_vld_o
);

    logic [TILE-1:0][TILE-1:0][ACC_W-1:0] acc;       // running sums
    logic [TILE-1:0][TILE-1:0][ACC_W-1:0] acc_next;
    idx_t q_tag;    // tile tags follow the fixed loop order
    idx_t k_tag;
    logic in_tile;  // first seen, last not yet

    //////////////////////////////////////////////////////////////////////
    // 4x4 by 4x4 multiply, K used row-wise so no transpose is needed
    //////////////////////////////////////////////////////////////////////
    always_comb begin : tile_mac
        logic signed [2*D_W-1:0] prod;
        logic signed [ACC_W-1:0] part;
        prod = '0;
        part = '0;
        for (int r = 0; r < TILE; r++) begin
            for (int c = 0; c < TILE; c++) begin
                part = '0;
                for (int k = 0; k < TILE; k++) begin
                    prod = $signed(opnd_i.q_tile[r][k]) * $signed(opnd_i.k_tile[c][k]);
                    part = part + ACC_W'(prod);  // q16.16, sign extended
                end
                acc_next[r][c] = opnd_i.first ? part : acc[r][c] + part;
            end
        end
    end

    always_ff @(posedge I_CLK) begin
        if (opnd_vld_i) begin
            acc <= acc_next;
        end
        if (opnd_vld_i && opnd_i.last) begin  // held while the next tile builds
            score_o.sum    <= acc_next;
            score_o.q_line <= q_tag;
            score_o.k_line <= k_tag;
        end
    end

    always_ff @(posedge I_CLK or negedge I_RST_N) begin
        if (!I_RST_N) begin
            score_vld_o <= 1'b0;
            q_tag       <= '0;
            k_tag       <= '0;
            in_tile     <= 1'b0;
        end else begin
            score_vld_o <= opnd_vld_i && opnd_i.last;
            if (opnd_vld_i) begin
                in_tile <= !opnd_i.last;
            end
            if (opnd_vld_i && opnd_i.last) begin
                k_tag <= k_tag + 1'b1;
                if (k_tag == idx_t'(K_TILES-1)) begin
                    k_tag <= '0;
                    q_tag <= (q_tag == idx_t'(Q_TILES-1)) ? '0 : q_tag + 1'b1;
                end
            end
        end
    end

    // a new tile opens only after the previous one closed
    assert property (@(posedge I_CLK) disable iff (!I_RST_N)
        (opnd_vld_i && opnd_i.first) |-> !in_tile)
        else $error("score_accum: first beat while a tile is still open");

endmodule

//--- testbench/tb_attn_score.sv
`timescale 1ns/100ps

module tb_attn_score import attn_pkg::*; ();

    localparam int     DK          = COL_TILES*TILE;
    localparam int     N_REQ       = Q_TILES*K_TILES*COL_TILES;
    localparam int     N_BEAT      = Q_TILES*K_TILES*TILE;
    localparam int     RUN_TIMEOUT = 2000;
    localparam longint MAX_V       = 2**(D_W-1) - 1;
    localparam longint MIN_V       = -(2**(D_W-1));
    localparam longint SCALE_REF   = 64;  // 1/sqrt(16) in q8.8

    logic     I_CLK;
    logic     I_RST_N;
    logic     start_i   = 1'b0;
    rd_req_t  rd_req_o;
    logic     rd_req_vld_o;
    rd_data_t rd_data_i = '0;
    logic     rd_vld_i  = 1'b0;
    wr_t      wr_o;
    logic     wr_vld_o;
    logic     done_o;

    logic signed [D_W-1:0] q_mat [Q_TILES*TILE][DK];
    logic signed [D_W-1:0] k_mat [K_TILES*TILE][DK];
    int       seed      = 32'hebb5_3e4c;
    int       mism_cnt  = 0;
    int       fault_cnt = 0;
    int       wait_cnt  = 0;      // cycles until the memory answers
    rd_req_t  req_q;
    logic [6:0] req_cnt  = '0;
    logic [6:0] beat_cnt = '0;
    logic [1:0] done_cnt = '0;
    logic     new_run   = 1'b0;   // clears the counters with the first start
    logic     idle_tb   = 1'b1;   // engine expected quiet
    logic     sat_run   = 1'b0;
    logic     run_ok    = 1'b0;
    string    test_name = "reset";

    tb_clock u_tb_clock (.clk_o(I_CLK), .rst_n_o(I_RST_N));

    attn_score_top dut0 (.*);

    //////////////////////////////////////////////////////////////////////
    // reference model and helpers
    //////////////////////////////////////////////////////////////////////
    function automatic logic [D_W-1:0] expect_elem(input int qr, input int kr);
        longint sum;
        longint v;
        sum = 0;
        for (int j = 0; j < DK; j++) begin
            sum += longint'(q_mat[qr][j]) * longint'(k_mat[kr][j]);  // K row read as column
        end
        v = ((sum >>> FRAC) * SCALE_REF) >>> FRAC;
        if (v > MAX_V) begin
            v = MAX_V;
        end else if (v < MIN_V) begin
            v = MIN_V;
        end
        return v[D_W-1:0];
    endfunction

    function automatic logic [TILE-1:0][D_W-1:0] expect_row(input idx_t qi, input idx_t ki,
                                                           input idx_t r);
        logic [TILE-1:0][D_W-1:0] row;
        for (int c = 0; c < TILE; c++) begin
            row[c] = expect_elem(qi*TILE + r, ki*TILE + c);
        end
        return row;
    endfunction

    function automatic logic all_clipped(input logic [TILE-1:0][D_W-1:0] row);
        logic ok;
        ok = 1'b1;
        for (int c = 0; c < TILE; c++) begin
            if (row[c] != D_W'(MAX_V) && row[c] != D_W'(MIN_V)) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    task automatic note_mismatch(input string what, input logic [63:0] exp,
                                 input logic [63:0] act);
        mism_cnt++;
        $display("mismatch %s %s expected %h actual %h", test_name, what, exp, act);
    endtask

    task automatic note_fault(input string msg);
        fault_cnt++;
        $display("%s (test %s)", msg, test_name);
    endtask

    task automatic fill_mem(input logic big);
        for (int i = 0; i < Q_TILES*TILE; i++) begin
            for (int j = 0; j < DK; j++) begin
                if (big) begin
                    q_mat[i][j] = 16'sh7000 + ($random(seed) & 'hfff);
                end else begin
                    q_mat[i][j] = $random(seed) % 512;
                end
            end
        end
        for (int i = 0; i < K_TILES*TILE; i++) begin
            for (int j = 0; j < DK; j++) begin
                if (big) begin
                    k_mat[i][j] = 16'sh7000 + ($random(seed) & 'hfff);
                end else begin
                    k_mat[i][j] = $random(seed) % 512;
                end
                if (big && i % 2 == 1) begin
                    k_mat[i][j] = -k_mat[i][j];  // odd k rows clip low
                end
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // tile memory answering after 1 to 4 cycles
    //////////////////////////////////////////////////////////////////////
    always @(negedge I_CLK) begin
        rd_vld_i = 1'b0;
        if (wait_cnt != 0) begin
            wait_cnt = wait_cnt - 1;
            if (wait_cnt == 0) begin
                rd_vld_i = 1'b1;
                for (int r = 0; r < TILE; r++) begin
                    for (int k = 0; k < TILE; k++) begin
                        rd_data_i.q_tile[r][k] = q_mat[req_q.q_line*TILE + r][req_q.col*TILE + k];
                        rd_data_i.k_tile[r][k] = k_mat[req_q.k_line*TILE + r][req_q.col*TILE + k];
                    end
                end
            end
        end
        if (rd_req_vld_o) begin
            assert (wait_cnt == 0) else note_fault("a second read was issued while one was open");
            req_q    = rd_req_o;
            wait_cnt = 1 + ($random(seed) & 3);
        end
    end

    always @(posedge I_CLK) begin
        if (new_run) begin
            req_cnt  <= '0;
            beat_cnt <= '0;
            done_cnt <= '0;
        end else begin
            req_cnt  <= req_cnt + rd_req_vld_o;
            beat_cnt <= beat_cnt + wr_vld_o;
            done_cnt <= done_cnt + done_o;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////
    quiet_idle: assert property (@(posedge I_CLK) disable iff (!I_RST_N)
        idle_tb |-> !(rd_req_vld_o || wr_vld_o || done_o))
        else note_fault("the engine drove an output strobe while idle");

    // q outer, k, col inner packs into a plain 6 bit count
    req_order: assert property (@(posedge I_CLK) disable iff (!I_RST_N)
        rd_req_vld_o |-> rd_req_o == rd_req_t'(req_cnt[5:0]) && req_cnt < N_REQ)
        else note_mismatch("request", $sampled(req_cnt), $sampled(rd_req_o));

    beat_order: assert property (@(posedge I_CLK) disable iff (!I_RST_N)
        wr_vld_o |-> {wr_o.q_line, wr_o.k_line, wr_o.row} == beat_cnt[5:0] && beat_cnt < N_BEAT)
        else note_mismatch("write tag", $sampled(beat_cnt),
                           {$sampled(wr_o.q_line), $sampled(wr_o.k_line), $sampled(wr_o.row)});

    row_value: assert property (@(posedge I_CLK) disable iff (!I_RST_N)
        wr_vld_o |-> wr_o.data == expect_row(wr_o.q_line, wr_o.k_line, wr_o.row))
        else note_mismatch("row", expect_row($sampled(wr_o.q_line), $sampled(wr_o.k_line),
                                             $sampled(wr_o.row)), $sampled(wr_o.data));

    row_clipped: assert property (@(posedge I_CLK) disable iff (!I_RST_N)
        (wr_vld_o && sat_run) |-> all_clipped(wr_o.data))
        else note_fault("a row in the large value run was not clipped to the limits");

    done_once: assert property (@(posedge I_CLK) disable iff (!I_RST_N)
        done_o |-> beat_cnt == N_BEAT && req_cnt == N_REQ && done_cnt == 0)
        else note_fault("done_o came early, twice, or with a wrong beat or request count");

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////
    task automatic end_sim();
        $display("errors: mismatch %0d, other %0d", mism_cnt, fault_cnt);
        if (mism_cnt == 0 && fault_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    task automatic run_test(input string name, input logic big, output logic seen);
        fill_mem(big);
        test_name = name;
        sat_run   = big;
        @(negedge I_CLK);
        idle_tb = 1'b0;
        start_i = 1'b1;
        new_run = 1'b1;
        seen    = 1'b0;
        for (int n = 0; n < RUN_TIMEOUT && !seen; n++) begin
            @(negedge I_CLK);
            new_run = 1'b0;
            start_i = (n == 40);  // ignored while running
            seen    = done_o;
        end
        if (!seen) begin
            note_fault("timeout, done_o never pulsed");
        end else begin
            @(negedge I_CLK);
            idle_tb = 1'b1;
            repeat (8) @(negedge I_CLK);
        end
    endtask

    initial begin
        for (int n = 0; n < 50 && I_RST_N !== 1'b1; n++) begin
            @(negedge I_CLK);
        end
        if (I_RST_N !== 1'b1) begin
            note_fault("reset was never released");
        end else begin
            repeat (5) @(negedge I_CLK);  // quiet before start
            run_test("random", 1'b0, run_ok);
            if (run_ok) begin
                run_test("saturate", 1'b1, run_ok);
            end
        end
        end_sim();
    end

endmodule

//--- testbench/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o   = 1'b0;
        rst_n_o = 1'b0;
        repeat (10) @(negedge clk_o);  // reset held for 10 cycles
        rst_n_o = 1'b1;
    end

    always #10 clk_o = ~clk_o;  // 20 ns period

endmodule

//--- tile_fetch/tile_fetch.sv
`timescale 1ns/100ps

module tile_fetch import attn_pkg::*; (
    input  logic     I_CLK,
    input  logic     I_RST_N,
    input  logic     start_i,
    input  logic     rd_vld_i,
    input  rd_data_t rd_data_i,
    input  logic     tile_done_i,
    output rd_req_t  rd_req_o,
    output logic     rd_req_vld_o,
    output opnd_t    opnd_o,
    output logic     opnd_vld_o,
    output logic     done_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,   // request on the bus this cycle
        S_WAIT,  // one read outstanding
        S_FIN    // all reads done, writer still draining
    } state_t;

    state_t state;
    idx_t   q_cnt;
    idx_t   k_cnt;
    idx_t   col_cnt;
    logic   last_fetch;
    logic [$clog2(Q_TILES*K_TILES)-1:0] tile_cnt;  // finished tiles

    assign last_fetch = (q_cnt == idx_t'(Q_TILES-1)) && (k_cnt == idx_t'(K_TILES-1)) &&
                        (col_cnt == idx_t'(COL_TILES-1));

    assign rd_req_o     = '{q_line: q_cnt, k_line: k_cnt, col: col_cnt};
    assign rd_req_vld_o = (state == S_REQ);

    //////////////////////////////////////////////////////////////////////
    // sequencer, q outer, k middle, col inner
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge I_CLK or negedge I_RST_N) begin
        if (!I_RST_N) begin
            state      <= S_IDLE;
            q_cnt      <= '0;
            k_cnt      <= '0;
            col_cnt    <= '0;
            tile_cnt   <= '0;
            opnd_vld_o <= 1'b0;
            done_o     <= 1'b0;
        end else begin
            opnd_vld_o <= 1'b0;
            done_o     <= 1'b0;
            if (state != S_IDLE && tile_done_i) begin
                tile_cnt <= tile_cnt + 1'b1;
            end
            case (state)
                S_IDLE: begin
                    if (start_i) begin  // only accepted here
                        state    <= S_REQ;
                        q_cnt    <= '0;
                        k_cnt    <= '0;
                        col_cnt  <= '0;
                        tile_cnt <= '0;
                    end
                end
                S_REQ: begin
                    state <= S_WAIT;
                end
                S_WAIT: begin
                    if (rd_vld_i) begin
                        opnd_vld_o <= 1'b1;
                        col_cnt    <= col_cnt + 1'b1;
                        if (col_cnt == idx_t'(COL_TILES-1)) begin
                            col_cnt <= '0;
                            k_cnt   <= k_cnt + 1'b1;
                            if (k_cnt == idx_t'(K_TILES-1)) begin
                                k_cnt <= '0;
                                q_cnt <= q_cnt + 1'b1;
                            end
                        end
                        state <= last_fetch ? S_FIN : S_REQ;
                    end
                end
                default: begin  // S_FIN
                    if (tile_done_i && tile_cnt == Q_TILES*K_TILES-1) begin
                        state  <= S_IDLE;
                        done_o <= 1'b1;
                    end
                end
            endcase
        end
    end

    // operand pair, tags first/last from the column index
    always_ff @(posedge I_CLK) begin
        if (state == S_WAIT && rd_vld_i) begin
            opnd_o.q_tile <= rd_data_i.q_tile;
            opnd_o.k_tile <= rd_data_i.k_tile;
            opnd_o.first  <= (col_cnt == '0);
            opnd_o.last   <= (col_cnt == idx_t'(COL_TILES-1));
        end
    end

    // memory must stay quiet unless a read is outstanding
    assert property (@(posedge I_CLK) disable iff (!I_RST_N)
        (state == S_IDLE) |-> !rd_vld_i)
        else $error("tile_fetch: read data arrived while idle");

endmodule

//--- verilog/attn_score_top.sv
`timescale 1ns/100ps

module attn_score_top import attn_pkg::*; (
    input  logic     I_CLK,
    input  logic     I_RST_N,
    input  logic     start_i,
    output rd_req_t  rd_req_o,
    output logic     rd_req_vld_o,
    input  rd_data_t rd_data_i,
    input  logic     rd_vld_i,
    output wr_t      wr_o,
    output logic     wr_vld_o,
    output logic     done_o
);

    opnd_t  opnd;       // fetcher to accumulator
    logic   opnd_vld;
    score_t score;      // accumulator to writer
    logic   score_vld;
    logic   tile_done;  // writer back to fetcher

    tile_fetch u_tile_fetch (
        .I_CLK        (I_CLK),
        .I_RST_N      (I_RST_N),
        .start_i      (start_i),
        .rd_vld_i     (rd_vld_i),
        .rd_data_i    (rd_data_i),
        .tile_done_i  (tile_done),
        .rd_req_o     (rd_req_o),
        .rd_req_vld_o (rd_req_vld_o),
        .opnd_o       (opnd),
        .opnd_vld_o   (opnd_vld),
        .done_o       (done_o)
    );

    score_accum u_score_accum (
        .I_CLK       (I_CLK),
        .I_RST_N     (I_RST_N),
        .opnd_i      (opnd),
        .opnd_vld_i  (opnd_vld),
        .score_o     (score),
        .score_vld_o (score_vld)
    );

    score_writer u_score_writer (
        .I_CLK       (I_CLK),
        .I_RST_N     (I_RST_N),
        .score_i     (score),
        .score_vld_i (score_vld),
        .wr_o        (wr_o),
        .wr_vld_o    (wr_vld_o),
        .tile_done_o (tile_done)
    );

endmodule

//--- verilog/score_writer.sv
`timescale 1ns/100ps

module score_writer import attn_pkg::*; (
    input  logic   I_CLK,
    input  logic   I_RST_N,
    input  score_t score_i,
    input  logic   score_vld_i,
    output wr_t    wr_o,
    output logic   wr_vld_o,
    output logic   tile_done_o
);

    logic [TILE-1:0][TILE-1:0][ACC_W-1:0] sum_q;  // latched tile
    idx_t q_tag;
    idx_t k_tag;
    idx_t row;
    logic busy;

    // drop to q8.8, scale by 1/sqrt(d_k), clip to 16 bits
    function automatic logic [D_W-1:0] scale_sat(input logic [ACC_W-1:0] sum);
        logic signed [ACC_W-1:0]     whole;
        logic signed [ACC_W+D_W-1:0] prod;
        whole = $signed(sum) >>> FRAC;
        prod  = (whole * SCALE_DK) >>> FRAC;
        if (&prod[ACC_W+D_W-1:D_W-1] || ~|prod[ACC_W+D_W-1:D_W-1]) begin
            return prod[D_W-1:0];  // fits
        end else if (prod[ACC_W+D_W-1]) begin
            return {1'b1, {(D_W-1){1'b0}}};
        end else begin
            return {1'b0, {(D_W-1){1'b1}}};
        end
    endfunction

    always_ff @(posedge I_CLK) begin
        if (score_vld_i) begin
            sum_q <= score_i.sum;
            q_tag <= score_i.q_line;
            k_tag <= score_i.k_line;
        end
    end

    always_ff @(posedge I_CLK or negedge I_RST_N) begin
        if (!I_RST_N) begin
            busy <= 1'b0;
            row  <= '0;
        end else if (score_vld_i) begin
            busy <= 1'b1;
            row  <= '0;
        end else if (busy) begin
            row <= row + 1'b1;
            if (row == idx_t'(TILE-1)) begin
                busy <= 1'b0;
            end
        end
    end

    always_comb begin
        wr_o.q_line = q_tag;
        wr_o.k_line = k_tag;
        wr_o.row    = row;
        for (int c = 0; c < TILE; c++) begin
            wr_o.data[c] = scale_sat(sum_q[row][c]);
        end
    end

    assign wr_vld_o    = busy;
    assign tile_done_o = busy && (row == idx_t'(TILE-1));  // with the fourth beat

    // reads take longer than the drain, so tiles never overlap here
    assert property (@(posedge I_CLK) disable iff (!I_RST_N)
        score_vld_i |-> !busy)
        else $error("score_writer: new score tile while still writing");

endmodule
